/* loader_pkg.sv */
/*
 * Download loader package
 * Types, download index codes, CRT file layout constants and the
 * page-zero BASIC pointer addresses shared by the loader blocks
 */
`default_nettype none

package loader_pkg;

	// ========================================
	// Basic types
	// ========================================
	localparam int unsigned ADDR_W = 25;

	typedef logic [ADDR_W-1:0] mem_addr_t;
	typedef logic [7:0]        byte_t;

	// Index codes sent by the host with each download
	localparam byte_t idx_prg = 8'd4;
	localparam byte_t idx_crt = 8'd5;

	// ========================================
	// CRT file layout
	// ========================================
	// Cartridge data area in memory
	localparam mem_addr_t CRT_BASE_ADDR = 25'h100000;

	// Cartridge header offsets
	// The ID high byte comes first
	localparam mem_addr_t CRT_ID_OFFSET    = 25'h16;
	localparam mem_addr_t CRT_EXROM_OFFSET = 25'h18;
	localparam mem_addr_t CRT_GAME_OFFSET  = 25'h19;

	// First CHIP packet follows the 64 byte file header
	localparam mem_addr_t CRT_CHIP_OFFSET = 25'h40;

	// Banks start on 8 KB boundaries
	localparam int unsigned BANK_ALIGN_BITS = 13;
	localparam int unsigned CHIP_HDR_BYTES  = 16;

	// CHIP packet header
	// Multi-byte fields are big endian
	typedef union packed {
		byte_t [0:15] bytes;
		struct packed {
			logic [31:0] signature;
			logic [31:0] pkt_len;
			logic [15:0] chip_type;
			logic [15:0] bank_num;
			logic [15:0] load_addr;
			logic [15:0] image_size;
		} fields;
	} chip_hdr_u;

	// ========================================
	// Page zero BASIC pointers
	// ========================================
	localparam logic [8:0] ZP_END = 9'h100;

	localparam byte_t ZP_TXTTAB_LO     = 8'h2B;
	localparam byte_t ZP_TXTTAB_HI     = 8'h2C;
	localparam byte_t ZP_VARTAB_LO     = 8'h2D;
	localparam byte_t ZP_VARTAB_HI     = 8'h2E;
	localparam byte_t ZP_ARYTAB_LO     = 8'h2F;
	localparam byte_t ZP_ARYTAB_HI     = 8'h30;
	localparam byte_t ZP_STREND_LO     = 8'h31;
	localparam byte_t ZP_STREND_HI     = 8'h32;
	localparam byte_t ZP_SAVE_START_LO = 8'hAC;
	localparam byte_t ZP_SAVE_START_HI = 8'hAD;
	localparam byte_t ZP_LOAD_END_LO   = 8'hAE;
	localparam byte_t ZP_LOAD_END_HI   = 8'hAF;

	// Start of BASIC program text after power on
	localparam logic [15:0] TXTTAB_VALUE = 16'h0801;

endpackage

`default_nettype wire

/* prg_parser.sv */
/*
 * PRG parser
 * Takes the two byte load address from a PRG download, turns each
 * following byte into a memory write and tracks the end address
 */
`timescale 1ns/10ps
`default_nettype none

module prg_parser (
	input  wire                   clk_sys,
	input  wire                   reset_n,
	input  wire                   ioctl_download_i,
	input  loader_pkg::byte_t     ioctl_index_i,
	input  loader_pkg::mem_addr_t ioctl_addr_i,
	input  loader_pkg::byte_t     ioctl_data_i,
	input  wire                   ioctl_wr_i,
	output logic                  prg_wr_o,
	output loader_pkg::mem_addr_t prg_addr_o,
	output loader_pkg::byte_t     prg_data_o,
	output logic                  prg_done_o,
	output logic [15:0]           prg_end_o
);
	import loader_pkg::*;

	logic        is_prg;
	logic        prg_byte;
	logic        data_byte;
	logic        old_download;
	logic [15:0] load_addr;

	assign is_prg    = (ioctl_index_i == idx_prg);
	assign prg_byte  = ioctl_wr_i && is_prg;
	// Bytes 0 and 1 carry the load address
	assign data_byte = prg_byte && (ioctl_addr_i > mem_addr_t'(1));

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			old_download <= 1'b0;
			prg_wr_o     <= 1'b0;
			prg_done_o   <= 1'b0;
		end else begin
			old_download <= ioctl_download_i;
			prg_wr_o     <= data_byte;
			// End of file seen on the falling edge of the download
			prg_done_o   <= is_prg && old_download && !ioctl_download_i;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (prg_byte && (ioctl_addr_i == '0)) begin
			load_addr[7:0] <= ioctl_data_i;
			prg_end_o[7:0] <= ioctl_data_i;
		end
		if (prg_byte && (ioctl_addr_i == mem_addr_t'(1))) begin
			load_addr[15:8] <= ioctl_data_i;
			prg_end_o[15:8] <= ioctl_data_i;
		end
		if (data_byte) begin
			prg_addr_o <= mem_addr_t'(load_addr);
			prg_data_o <= ioctl_data_i;
			load_addr  <= load_addr + 16'd1;
			prg_end_o  <= prg_end_o + 16'd1;
		end
	end

endmodule

`default_nettype wire

/* crt_parser.sv */
/*
 * CRT parser
 * Reads the cartridge header of a CRT download, walks its CHIP packets,
 * places each bank on an 8 KB boundary above the cartridge base and
 * reports one bank descriptor per packet
 */
`timescale 1ns/10ps
`default_nettype none

module crt_parser (
	input  wire                   clk_sys,
	input  wire                   reset_n,
	input  wire                   ioctl_download_i,
	input  loader_pkg::byte_t     ioctl_index_i,
	input  loader_pkg::mem_addr_t ioctl_addr_i,
	input  loader_pkg::byte_t     ioctl_data_i,
	input  wire                   ioctl_wr_i,
	output logic                  crt_wr_o,
	output loader_pkg::mem_addr_t crt_addr_o,
	output loader_pkg::byte_t     crt_data_o,
	output logic [15:0]           cart_id_o,
	output loader_pkg::byte_t     cart_exrom_o,
	output loader_pkg::byte_t     cart_game_o,
	output logic                  cart_attached_o,
	output logic                  bank_wr_o,
	output logic [15:0]           bank_num_o,
	output logic [15:0]           bank_laddr_o,
	output logic [15:0]           bank_size_o,
	output loader_pkg::byte_t     bank_type_o,
	output loader_pkg::mem_addr_t bank_raddr_o
);
	import loader_pkg::*;

	localparam mem_addr_t ALIGN_MASK = mem_addr_t'((1 << BANK_ALIGN_BITS) - 1);

	logic        is_crt;
	logic        crt_byte;
	logic        file_start;
	logic        chip_area;
	logic        hdr_start;
	logic        hdr_byte;
	logic        hdr_last;
	logic        data_byte;
	logic        old_download;
	logic        in_hdr;
	logic [3:0]  hdr_cnt;
	logic [31:0] blk_len;
	mem_addr_t   load_addr;
	chip_hdr_u   hdr_q;

	assign is_crt     = (ioctl_index_i == idx_crt);
	assign crt_byte   = ioctl_wr_i && is_crt;
	assign file_start = crt_byte && (ioctl_addr_i == '0);
	assign chip_area  = crt_byte && (ioctl_addr_i >= CRT_CHIP_OFFSET);

	// A packet starts when the previous data block is used up
	assign hdr_start = chip_area && !in_hdr && (blk_len == '0);
	assign hdr_byte  = chip_area && in_hdr;
	assign hdr_last  = hdr_byte && (hdr_cnt == 4'(CHIP_HDR_BYTES - 1));
	assign data_byte = chip_area && !in_hdr && (blk_len != '0);

	// ========================================
	// Packet walk
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			old_download    <= 1'b0;
			cart_attached_o <= 1'b0;
			crt_wr_o        <= 1'b0;
			bank_wr_o       <= 1'b0;
			in_hdr          <= 1'b0;
			hdr_cnt         <= '0;
			blk_len         <= '0;
		end else begin
			old_download <= ioctl_download_i;
			crt_wr_o     <= data_byte;
			bank_wr_o    <= hdr_last;

			// Detached while loading and attached once the file is complete
			if (is_crt && (old_download != ioctl_download_i))
				cart_attached_o <= old_download;

			if (file_start) begin
				in_hdr  <= 1'b0;
				hdr_cnt <= '0;
				blk_len <= '0;
			end else if (hdr_start) begin
				in_hdr  <= 1'b1;
				hdr_cnt <= 4'd1;
			end else if (hdr_byte) begin
				hdr_cnt <= hdr_cnt + 4'd1;
				if (hdr_last) begin
					in_hdr  <= 1'b0;
					// Packet length counts the header too
					blk_len <= hdr_q.fields.pkt_len - 32'(CHIP_HDR_BYTES);
				end
			end else if (data_byte) begin
				blk_len <= blk_len - 32'd1;
			end
		end
	end

	// ========================================
	// Header fields and data placement
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (crt_byte && (ioctl_addr_i == CRT_ID_OFFSET))
			cart_id_o[15:8] <= ioctl_data_i;
		if (crt_byte && (ioctl_addr_i == CRT_ID_OFFSET + mem_addr_t'(1)))
			cart_id_o[7:0] <= ioctl_data_i;
		if (crt_byte && (ioctl_addr_i == CRT_EXROM_OFFSET))
			cart_exrom_o <= ioctl_data_i;
		if (crt_byte && (ioctl_addr_i == CRT_GAME_OFFSET))
			cart_game_o <= ioctl_data_i;

		if (file_start)
			load_addr <= CRT_BASE_ADDR;

		if (hdr_start) begin
			hdr_q.bytes[0] <= ioctl_data_i;
			// Round up to the next bank boundary
			if ((load_addr & ALIGN_MASK) != '0)
				load_addr <= (load_addr | ALIGN_MASK) + mem_addr_t'(1);
		end

		if (hdr_byte)
			hdr_q.bytes[hdr_cnt] <= ioctl_data_i;
		if (hdr_last)
			bank_raddr_o <= load_addr;

		if (data_byte) begin
			crt_addr_o <= load_addr;
			crt_data_o <= ioctl_data_i;
			load_addr  <= load_addr + mem_addr_t'(1);
		end
	end

	assign bank_num_o   = hdr_q.fields.bank_num;
	assign bank_laddr_o = hdr_q.fields.load_addr;
	assign bank_size_o  = hdr_q.fields.image_size;
	assign bank_type_o  = hdr_q.fields.chip_type[7:0];

endmodule

`default_nettype wire

/* basic_ptr_init.sv */
/*
 * BASIC pointer init
 * After a PRG load, walks page zero and writes the pointer bytes
 * that a BASIC LOAD would have left behind
 */
`timescale 1ns/10ps
`default_nettype none

module basic_ptr_init (
	input  wire                   clk_sys,
	input  wire                   reset_n,
	input  wire                   prg_done_i,
	input  wire [15:0]            prg_end_i,
	input  wire                   port_busy_i,
	output logic                  zp_wr_o,
	output loader_pkg::mem_addr_t zp_addr_o,
	output loader_pkg::byte_t     zp_data_o,
	output logic                  zp_busy_o
);
	import loader_pkg::*;

	logic [8:0] zp_idx;
	logic       ptr_hit;
	byte_t      ptr_val;
	logic       walking;
	logic       issue;

	// Pointer map for the current page-zero address
	always_comb begin
		ptr_hit = 1'b1;
		ptr_val = 8'h00;
		case (zp_idx[7:0])
			ZP_TXTTAB_LO: ptr_val = TXTTAB_VALUE[7:0];
			ZP_TXTTAB_HI: ptr_val = TXTTAB_VALUE[15:8];
			ZP_SAVE_START_LO, ZP_SAVE_START_HI: ptr_val = 8'h00;
			ZP_VARTAB_LO, ZP_ARYTAB_LO, ZP_STREND_LO, ZP_LOAD_END_LO:
				ptr_val = prg_end_i[7:0];
			ZP_VARTAB_HI, ZP_ARYTAB_HI, ZP_STREND_HI, ZP_LOAD_END_HI:
				ptr_val = prg_end_i[15:8];
			default: ptr_hit = 1'b0;
		endcase
	end

	assign walking = zp_busy_o && !prg_done_i && (zp_idx != ZP_END);
	// Hold off one cycle after a strobe until the port reports busy
	assign issue   = walking && ptr_hit && !port_busy_i && !zp_wr_o;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			zp_busy_o <= 1'b0;
			zp_wr_o   <= 1'b0;
			zp_idx    <= '0;
		end else begin
			zp_wr_o <= issue;
			if (prg_done_i) begin
				zp_busy_o <= 1'b1;
				zp_idx    <= '0;
			end else if (zp_busy_o && (zp_idx == ZP_END)) begin
				zp_busy_o <= 1'b0;
			end else if ((walking && !ptr_hit) || issue) begin
				zp_idx <= zp_idx + 9'd1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (issue) begin
			zp_addr_o <= mem_addr_t'(zp_idx[7:0]);
			zp_data_o <= ptr_val;
		end
	end

endmodule

`default_nettype wire

/* mem_write_port.sv */
/*
 * Memory write port
 * Merges the parser write strobes into one pending write, holds it
 * toward memory until acknowledged and drives the download wait
 */
`timescale 1ns/10ps
`default_nettype none

module mem_write_port (
	input  wire                   clk_sys,
	input  wire                   reset_n,
	input  wire                   prg_wr_i,
	input  loader_pkg::mem_addr_t prg_addr_i,
	input  loader_pkg::byte_t     prg_data_i,
	input  wire                   crt_wr_i,
	input  loader_pkg::mem_addr_t crt_addr_i,
	input  loader_pkg::byte_t     crt_data_i,
	input  wire                   zp_wr_i,
	input  loader_pkg::mem_addr_t zp_addr_i,
	input  loader_pkg::byte_t     zp_data_i,
	input  wire                   mem_ack_i,
	output logic                  mem_req_o,
	output loader_pkg::mem_addr_t mem_addr_o,
	output loader_pkg::byte_t     mem_data_o,
	output logic                  port_busy_o
);
	import loader_pkg::*;

	logic      sel_wr;
	mem_addr_t sel_addr;
	byte_t     sel_data;

	// Only one source fires in any cycle
	always_comb begin
		sel_wr   = prg_wr_i || crt_wr_i || zp_wr_i;
		sel_addr = zp_addr_i;
		sel_data = zp_data_i;
		if (prg_wr_i) begin
			sel_addr = prg_addr_i;
			sel_data = prg_data_i;
		end else if (crt_wr_i) begin
			sel_addr = crt_addr_i;
			sel_data = crt_data_i;
		end
	end

	// ========================================
	// Pending write slot
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (!reset_n)
			mem_req_o <= 1'b0;
		else if (sel_wr)
			mem_req_o <= 1'b1;
		else if (mem_ack_i)
			mem_req_o <= 1'b0;
	end

	always_ff @(posedge clk_sys) begin
		if (sel_wr) begin
			mem_addr_o <= sel_addr;
			mem_data_o <= sel_data;
		end
	end

	// Busy for as long as a write is outstanding
	assign port_busy_o = mem_req_o;

endmodule

`default_nettype wire

/* loader_top.sv */
/*
 * Download loader top
 * Connects the PRG and CRT parsers, the page-zero pointer init
 * and the memory write port
 */
`timescale 1ns/10ps
`default_nettype none

module loader_top (
	input  wire                   clk_sys,
	input  wire                   reset_n,
	input  wire                   ioctl_download_i,
	input  loader_pkg::byte_t     ioctl_index_i,
	input  loader_pkg::mem_addr_t ioctl_addr_i,
	input  loader_pkg::byte_t     ioctl_data_i,
	input  wire                   ioctl_wr_i,
	output logic                  ioctl_wait_o,
	output logic                  mem_req_o,
	output loader_pkg::mem_addr_t mem_addr_o,
	output loader_pkg::byte_t     mem_data_o,
	input  wire                   mem_ack_i,
	output logic [15:0]           cart_id_o,
	output loader_pkg::byte_t     cart_exrom_o,
	output loader_pkg::byte_t     cart_game_o,
	output logic                  cart_attached_o,
	output logic                  bank_wr_o,
	output logic [15:0]           bank_num_o,
	output logic [15:0]           bank_laddr_o,
	output logic [15:0]           bank_size_o,
	output loader_pkg::byte_t     bank_type_o,
	output loader_pkg::mem_addr_t bank_raddr_o,
	output logic                  zp_busy_o
);
	import loader_pkg::*;

	logic        prg_wr;
	mem_addr_t   prg_addr;
	byte_t       prg_data;
	logic        prg_done;
	logic [15:0] prg_end;
	logic        crt_wr;
	mem_addr_t   crt_addr;
	byte_t       crt_data;
	logic        zp_wr;
	mem_addr_t   zp_addr;
	byte_t       zp_data;
	logic        port_busy;

	prg_parser i_prg_parser (
		.clk_sys, .reset_n, .ioctl_download_i, .ioctl_index_i,
		.ioctl_addr_i, .ioctl_data_i, .ioctl_wr_i,
		.prg_wr_o(prg_wr), .prg_addr_o(prg_addr), .prg_data_o(prg_data),
		.prg_done_o(prg_done), .prg_end_o(prg_end)
	);

	crt_parser i_crt_parser (
		.clk_sys, .reset_n, .ioctl_download_i, .ioctl_index_i,
		.ioctl_addr_i, .ioctl_data_i, .ioctl_wr_i,
		.crt_wr_o(crt_wr), .crt_addr_o(crt_addr), .crt_data_o(crt_data),
		.cart_id_o, .cart_exrom_o, .cart_game_o, .cart_attached_o,
		.bank_wr_o, .bank_num_o, .bank_laddr_o, .bank_size_o,
		.bank_type_o, .bank_raddr_o
	);

	// Runs only after a PRG download has finished
	basic_ptr_init i_basic_ptr_init (
		.clk_sys, .reset_n, .prg_done_i(prg_done), .prg_end_i(prg_end),
		.port_busy_i(port_busy), .zp_wr_o(zp_wr), .zp_addr_o(zp_addr),
		.zp_data_o(zp_data), .zp_busy_o
	);

	mem_write_port i_mem_write_port (
		.clk_sys, .reset_n,
		.prg_wr_i(prg_wr), .prg_addr_i(prg_addr), .prg_data_i(prg_data),
		.crt_wr_i(crt_wr), .crt_addr_i(crt_addr), .crt_data_i(crt_data),
		.zp_wr_i(zp_wr), .zp_addr_i(zp_addr), .zp_data_i(zp_data),
		.mem_ack_i, .mem_req_o, .mem_addr_o, .mem_data_o,
		.port_busy_o(port_busy)
	);

	// Pending write stalls the host byte stream
	assign ioctl_wait_o = port_busy;

endmodule

`default_nettype wire

/* loader_sva.sv */
/*
 * Loader protocol checks
 * Concurrent assertions on the memory handshake, the download wait
 * and the bank descriptor strobe, bound to the loader top level
 */
`timescale 1ns/10ps
`default_nettype none

module loader_sva (
	input wire                        clk_sys,
	input wire                        reset_n,
	input wire                        ioctl_wr_i,
	input wire                        ioctl_wait_o,
	input wire                        mem_req_o,
	input wire                        mem_ack_i,
	input wire loader_pkg::mem_addr_t mem_addr_o,
	input wire loader_pkg::byte_t     mem_data_o,
	input wire                        bank_wr_o
);

	// Pending write held unchanged until memory acknowledges
	a_req_stable: assert property (@(posedge clk_sys) disable iff (!reset_n)
		mem_req_o && !mem_ack_i |=> mem_req_o && $stable(mem_addr_o) && $stable(mem_data_o))
	else $error("memory request changed before acknowledge");

	a_req_drop: assert property (@(posedge clk_sys) disable iff (!reset_n)
		mem_req_o && mem_ack_i |=> !mem_req_o)
	else $error("memory request still high after acknowledge");

	// Host must hold off while the port is busy
	a_wr_wait: assert property (@(posedge clk_sys) disable iff (!reset_n)
		ioctl_wait_o |-> !ioctl_wr_i)
	else $error("download byte written while wait is high");

	a_bank_pulse: assert property (@(posedge clk_sys) disable iff (!reset_n)
		bank_wr_o |=> !bank_wr_o)
	else $error("bank descriptor strobe longer than one cycle");

endmodule

bind loader_top loader_sva i_loader_sva (.*);

`default_nettype wire

/* tb_loader.sv */
/*
 * Loader testbench
 * Streams PRG and CRT files from a table into the loader, models a
 * memory with random acknowledge delay and checks every write
 */
`timescale 1ns/10ps
`default_nettype none

module tb_loader;
	import loader_pkg::*;

	localparam int SIG_WAIT     = 0;
	localparam int SIG_ZP_BUSY  = 1;
	localparam int SIG_ATTACHED = 2;
	localparam int SIG_MEM_REQ  = 3;

	// Columns: kind, load address or chip count, data length or first chip size,
	// size of the later chips
	typedef struct packed {
		byte_t       kind;
		logic [15:0] base;
		logic [15:0] len;
		logic [15:0] chip;
	} file_row_t;

	logic        clk_sys          = 1'b0;
	logic        reset_n          = 1'b0;
	logic        ioctl_download_i = 1'b0;
	byte_t       ioctl_index_i    = 8'h00;
	mem_addr_t   ioctl_addr_i     = '0;
	byte_t       ioctl_data_i     = 8'h00;
	logic        ioctl_wr_i       = 1'b0;
	logic        mem_ack_i        = 1'b0;
	logic        ioctl_wait_o;
	logic        mem_req_o;
	mem_addr_t   mem_addr_o;
	byte_t       mem_data_o;
	logic [15:0] cart_id_o;
	byte_t       cart_exrom_o;
	byte_t       cart_game_o;
	logic        cart_attached_o;
	logic        bank_wr_o;
	logic [15:0] bank_num_o;
	logic [15:0] bank_laddr_o;
	logic [15:0] bank_size_o;
	byte_t       bank_type_o;
	mem_addr_t   bank_raddr_o;
	logic        zp_busy_o;

	integer      seed = 32'h3e7f_d27a;
	file_row_t   file_tab [4];
	byte_t       file_q [$];
	mem_addr_t   exp_addr_q [$];
	byte_t       exp_data_q [$];
	mem_addr_t   wr_addr_q [$];
	byte_t       wr_data_q [$];
	mem_addr_t   exp_raddr_q [$];
	mem_addr_t   got_raddr_q [$];
	logic [55:0] exp_desc_q [$];
	logic [55:0] got_desc_q [$];
	logic [15:0] exp_id;
	byte_t       exp_exrom;
	byte_t       exp_game;
	logic        req_seen  = 1'b0;
	int          ack_delay = 0;

	loader_top i_dut (.*);

	initial begin
		forever #10 clk_sys = ~clk_sys;
	end

	// ========================================
	// Memory model and bank monitor
	// ========================================
	always @(negedge clk_sys) begin
		if (mem_ack_i) begin
			mem_ack_i = 1'b0;
		end else if (mem_req_o) begin
			if (!req_seen) begin
				req_seen  = 1'b1;
				ack_delay = $unsigned($random(seed)) % 32'd6;
			end
			if (ack_delay == 0) begin
				wr_addr_q.push_back(mem_addr_o);
				wr_data_q.push_back(mem_data_o);
				mem_ack_i = 1'b1;
				req_seen  = 1'b0;
			end else begin
				ack_delay = ack_delay - 1;
			end
		end
	end

	always @(negedge clk_sys) begin
		if (bank_wr_o) begin
			got_raddr_q.push_back(bank_raddr_o);
			got_desc_q.push_back({bank_type_o, bank_num_o, bank_laddr_o, bank_size_o});
		end
	end

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp)
			stop_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
	endtask

	function automatic logic signal_level(input int sel);
		case (sel)
			SIG_WAIT:     return ioctl_wait_o;
			SIG_ZP_BUSY:  return zp_busy_o;
			SIG_ATTACHED: return cart_attached_o;
			default:      return mem_req_o;
		endcase
	endfunction

	task automatic wait_until(input int sel, input logic level, input int limit,
			input string what);
		int n;
		n = 0;
		while (signal_level(sel) !== level) begin
			if (n == limit)
				stop_run({"Timed out waiting for ", what});
			n++;
			@(negedge clk_sys);
		end
	endtask

	task automatic push_exp(input mem_addr_t addr, input byte_t data);
		exp_addr_q.push_back(addr);
		exp_data_q.push_back(data);
	endtask

	task automatic push_word(input logic [15:0] w);
		file_q.push_back(w[15:8]);
		file_q.push_back(w[7:0]);
	endtask

	// ========================================
	// File builders and reference model
	// ========================================
	task automatic build_prg(input file_row_t row);
		logic [15:0] end_addr;
		byte_t       d;
		file_q.delete();
		push_word({row.base[7:0], row.base[15:8]});
		for (int i = 0; i < int'(row.len); i++) begin
			d = 8'($random(seed));
			file_q.push_back(d);
			push_exp(mem_addr_t'(row.base + 16'(i)), d);
		end
		// Pointers a BASIC LOAD leaves behind, in page-zero order
		end_addr = row.base + row.len;
		push_exp(25'h2B, 8'h01);
		push_exp(25'h2C, 8'h08);
		push_exp(25'h2D, end_addr[7:0]);
		push_exp(25'h2E, end_addr[15:8]);
		push_exp(25'h2F, end_addr[7:0]);
		push_exp(25'h30, end_addr[15:8]);
		push_exp(25'h31, end_addr[7:0]);
		push_exp(25'h32, end_addr[15:8]);
		push_exp(25'hAC, 8'h00);
		push_exp(25'hAD, 8'h00);
		push_exp(25'hAE, end_addr[7:0]);
		push_exp(25'hAF, end_addr[15:8]);
	endtask

	task automatic build_crt(input file_row_t row);
		mem_addr_t   cur;
		logic [15:0] size;
		byte_t       d;
		file_q.delete();
		for (int i = 0; i < 64; i++)
			file_q.push_back(8'($random(seed)));
		exp_id    = {file_q[22], file_q[23]};
		exp_exrom = file_q[24];
		exp_game  = file_q[25];
		cur = 25'h100000;
		for (int k = 0; k < int'(row.base); k++) begin
			size = (k == 0) ? row.len : row.chip;
			// Round up to the next 8 KB bank
			cur = ((cur + 25'h1FFF) >> 13) << 13;
			push_word(16'h4348);
			push_word(16'h4950);
			push_word(16'h0000);
			push_word(size + 16'd16);
			push_word(16'h0002);
			push_word(16'(k));
			push_word(16'h8000);
			push_word(size);
			exp_raddr_q.push_back(cur);
			exp_desc_q.push_back({8'h02, 16'(k), 16'h8000, size});
			for (int j = 0; j < int'(size); j++) begin
				d = 8'($random(seed));
				file_q.push_back(d);
				push_exp(cur + mem_addr_t'(j), d);
			end
			cur = cur + mem_addr_t'(size);
		end
	endtask

	// ========================================
	// Download and checks
	// ========================================
	task automatic send_byte(input mem_addr_t addr, input byte_t data);
		ioctl_addr_i = addr;
		ioctl_data_i = data;
		ioctl_wr_i   = 1'b1;
		@(negedge clk_sys);
		ioctl_wr_i = 1'b0;
		// Wait rises two cycles after the byte is taken
		@(negedge clk_sys);
		@(negedge clk_sys);
		wait_until(SIG_WAIT, 1'b0, 20, "the download wait to clear");
	endtask

	task automatic run_file(input file_row_t row);
		ioctl_index_i    = row.kind;
		ioctl_download_i = 1'b1;
		@(negedge clk_sys);
		if (row.kind == idx_crt)
			wait_until(SIG_ATTACHED, 1'b0, 10, "cartridge detach at download start");
		for (int i = 0; i < file_q.size(); i++)
			send_byte(mem_addr_t'(i), file_q[i]);
		@(negedge clk_sys);
		ioctl_download_i = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic check_writes;
		check_value("mem write count", 32'(wr_addr_q.size()), 32'(exp_addr_q.size()));
		foreach (exp_addr_q[i]) begin
			check_value("mem_addr_o", 32'(wr_addr_q[i]), 32'(exp_addr_q[i]));
			check_value("mem_data_o", 32'(wr_data_q[i]), 32'(exp_data_q[i]));
		end
		exp_addr_q.delete();
		exp_data_q.delete();
		wr_addr_q.delete();
		wr_data_q.delete();
	endtask

	task automatic check_banks;
		check_value("bank_wr_o count", 32'(got_raddr_q.size()), 32'(exp_raddr_q.size()));
		foreach (exp_raddr_q[i]) begin
			check_value("bank_raddr_o", 32'(got_raddr_q[i]), 32'(exp_raddr_q[i]));
			check_value("bank_type_o", 32'(got_desc_q[i][55:48]), 32'(exp_desc_q[i][55:48]));
			check_value("bank_num_o", 32'(got_desc_q[i][47:32]), 32'(exp_desc_q[i][47:32]));
			check_value("bank_laddr_o", 32'(got_desc_q[i][31:16]), 32'(exp_desc_q[i][31:16]));
			check_value("bank_size_o", 32'(got_desc_q[i][15:0]), 32'(exp_desc_q[i][15:0]));
		end
		exp_raddr_q.delete();
		got_raddr_q.delete();
		exp_desc_q.delete();
		got_desc_q.delete();
	endtask

	initial begin
		file_tab[0] = '{idx_prg, 16'h0801, 16'd40, 16'd0};
		file_tab[1] = '{idx_crt, 16'd2, 16'd300, 16'd200};
		file_tab[2] = '{idx_crt, 16'd3, 16'd100, 16'd64};
		file_tab[3] = '{idx_prg, 16'hC000, 16'd25, 16'd0};

		repeat (4) @(negedge clk_sys);
		check_value("mem_req_o", 32'(mem_req_o), 32'd0);
		check_value("ioctl_wait_o", 32'(ioctl_wait_o), 32'd0);
		check_value("bank_wr_o", 32'(bank_wr_o), 32'd0);
		check_value("zp_busy_o", 32'(zp_busy_o), 32'd0);
		check_value("cart_attached_o", 32'(cart_attached_o), 32'd0);
		reset_n = 1'b1;

		foreach (file_tab[f]) begin
			if (file_tab[f].kind == idx_prg) begin
				build_prg(file_tab[f]);
				run_file(file_tab[f]);
				wait_until(SIG_ZP_BUSY, 1'b1, 10, "page-zero init to start");
				wait_until(SIG_ZP_BUSY, 1'b0, 2000, "page-zero init to finish");
			end else begin
				build_crt(file_tab[f]);
				run_file(file_tab[f]);
				wait_until(SIG_ATTACHED, 1'b1, 10, "cartridge attach after download");
				check_value("cart_id_o", 32'(cart_id_o), 32'(exp_id));
				check_value("cart_exrom_o", 32'(cart_exrom_o), 32'(exp_exrom));
				check_value("cart_game_o", 32'(cart_game_o), 32'(exp_game));
			end
			wait_until(SIG_MEM_REQ, 1'b0, 20, "the memory port to go idle");
			check_writes();
			check_banks();
		end

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
loader_pkg.sv
prg_parser.sv
crt_parser.sv
basic_ptr_init.sv
mem_write_port.sv
loader_top.sv
loader_sva.sv
tb_loader.sv

/* run_sim.sh */
#!/bin/sh
# Build the loader testbench with Verilator and run it
verilator --binary --timing --assert --top-module tb_loader -f verilog.f -o sim_loader \
	&& ./obj_dir/sim_loader \
	|| exit 1
